/* hdl/gmii_rx_assembler.sv */
`default_nettype none

module gmii_rx_assembler
	#(
	parameter int LINK_QUAL = 16				// clean cycles before link up
	)
	(
	input  wire                     xauiA_clk,
	input  wire                     reset_,
	input  wire  [7:0]              gmii_rxd,
	input  wire                     gmii_rx_dv,
	input  wire                     gmii_rx_er,
	input  wire                     fmac_rxd_en,
	input  wire                     sfp_los,
	output mac_rx_pkg::rx_beat_t    rx_beat,
	output mac_rx_pkg::frame_info_t frame_info,
	output logic                    linkup
	);

	import mac_rx_pkg::*;

	localparam int QW = $clog2(LINK_QUAL + 1);

	logic [QW-1:0]     los_cnt;		// run of cycles with sfp_los low
	logic              dv_q;		// dv last cycle, edge detect
	logic              in_frame;	// accepted frame in progress
	logic              end_pend;	// last beat waits one cycle
	logic              first_beat;	// next release carries sof
	logic [3:0]        byte_cnt;	// bytes in beat_data, 0..8
	logic [DATA_W-1:0] beat_data;
	logic [LEN_W-1:0]  frame_len;
	logic              frame_err;
	logic [CTRL_W-1:0] be_mask;
	logic              start_acc;
	logic              cont;
	logic              frame_end;
	logic              full;

	assign start_acc = gmii_rx_dv && !dv_q && fmac_rxd_en && linkup;	// gate at frame start
	assign cont      = gmii_rx_dv && dv_q && in_frame;
	assign frame_end = !gmii_rx_dv && dv_q && in_frame;
	assign full      = (byte_cnt == 4'd8);

	// low bits set for bytes present
	always_comb
	begin
		be_mask = '0;
		for (int i = 0; i < CTRL_W; i++)
			be_mask[i] = (i < byte_cnt);
	end

	// link qualification
	always_ff @(posedge xauiA_clk)
	begin
		if (!reset_)
		begin
			los_cnt <= '0;
			linkup  <= 1'b0;
		end
		else if (sfp_los)
		begin
			los_cnt <= '0;				// drop right away
			linkup  <= 1'b0;
		end
		else if (los_cnt == QW'(LINK_QUAL))
			linkup  <= 1'b1;
		else
			los_cnt <= los_cnt + 1'b1;
	end

	// byte packing, length and error
	always_ff @(posedge xauiA_clk)
	begin
		if (start_acc)
		begin
			beat_data <= {{(DATA_W-8){1'b0}}, gmii_rxd};	// new beat, upper bytes clear
			frame_len <= LEN_W'(1);
			frame_err <= gmii_rx_er;
		end
		else if (cont)
		begin
			if (full)
				beat_data <= {{(DATA_W-8){1'b0}}, gmii_rxd};
			else
				beat_data[byte_cnt[2:0]*8 +: 8] <= gmii_rxd;	// next lane
			if (frame_len != '1)
				frame_len <= frame_len + 1'b1;		// saturate
			frame_err <= frame_err | gmii_rx_er;
		end
	end

	// beat release and frame report
	always_ff @(posedge xauiA_clk)
	begin
		if (!reset_)
		begin
			dv_q       <= 1'b0;
			in_frame   <= 1'b0;
			end_pend   <= 1'b0;
			first_beat <= 1'b0;
			byte_cnt   <= '0;
			rx_beat    <= '0;
			frame_info <= '0;
		end
		else
		begin
			dv_q            <= gmii_rx_dv;
			rx_beat.vld     <= 1'b0;			// strobes default low
			frame_info.done <= 1'b0;
			if (end_pend)
			begin
				rx_beat    <= '{vld: 1'b1, data: beat_data, byte_en: be_mask,
				               sof: first_beat, eof: 1'b1};
				frame_info <= '{done: 1'b1, len: frame_len, err: frame_err};
				end_pend   <= 1'b0;
			end
			if (start_acc)
			begin
				in_frame   <= 1'b1;
				byte_cnt   <= 4'd1;
				first_beat <= 1'b1;
			end
			else if (cont)
			begin
				if (full)
				begin
					rx_beat    <= '{vld: 1'b1, data: beat_data, byte_en: '1,
					               sof: first_beat, eof: 1'b0};	// full, more to come
					first_beat <= 1'b0;
					byte_cnt   <= 4'd1;
				end
				else
					byte_cnt <= byte_cnt + 1'b1;
			end
			else if (frame_end)
			begin
				in_frame <= 1'b0;
				end_pend <= 1'b1;				// release next cycle with eof
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/mac_register_if.sv */
`default_nettype none

module mac_register_if
	#(
	parameter int RD_DELAY = 5					// start to done, in cycles
	)
	(
	input  wire                      xauiA_clk,
	input  wire                      reset_,
	input  wire                      reg_rd_start,
	input  wire  [15:0]              host_addr_reg,
	input  wire  [3:0]               SYS_ADDR,
	input  wire  [31:0]              fmac_ctrl,
	input  wire mac_rx_pkg::stat_bank_t bank,
	output mac_rx_pkg::reg_word_t    FMAC_REGDOUT,
	output logic                     reg_rd_done_out,
	output logic                     clear_stb,
	output mac_rx_pkg::reg_idx_t     clear_idx
	);

	import mac_rx_pkg::*;

	localparam int PIPE_N = RD_DELAY - 1;		// last stage is the output reg

	// one read in flight
	typedef struct packed {
		logic     stb;
		logic     sel;		// SYS_ADDR matched
		reg_idx_t idx;
	} rd_req_t;

	rd_req_t [PIPE_N-1:0] rd_pipe;
	rd_req_t              rd_last;
	reg_word_t            rd_word;
	logic                 rx_auto_clr_en;		// fmac_ctrl bit 7, rebuffered

	assign rd_last = rd_pipe[PIPE_N-1];

	// read mux, unselected and 12..15 give zero
	always_comb
	begin
		rd_word = '0;
		if (rd_last.sel && (rd_last.idx < N_STAT))
			rd_word = bank[rd_last.idx];
	end

	always_ff @(posedge xauiA_clk)
	begin
		if (!reset_)
		begin
			rd_pipe         <= '0;
			rx_auto_clr_en  <= 1'b0;
			reg_rd_done_out <= 1'b0;
			clear_stb       <= 1'b0;
			clear_idx       <= '0;
			FMAC_REGDOUT    <= '0;
		end
		else
		begin
			rx_auto_clr_en <= fmac_ctrl[7];
			rd_pipe[0]     <= '{stb: reg_rd_start,
			                    sel: (host_addr_reg[15:12] == SYS_ADDR),
			                    idx: host_addr_reg[5:2]};		// word address
			for (int i = 1; i < PIPE_N; i++)
				rd_pipe[i] <= rd_pipe[i-1];			// overlapping reads ok
			reg_rd_done_out <= rd_last.stb;
			clear_stb       <= rd_last.stb && rd_last.sel && rx_auto_clr_en;
			clear_idx       <= rd_last.idx;
			if (rd_last.stb)
				FMAC_REGDOUT <= rd_word;			// holds until next read
		end
	end

endmodule

`default_nettype wire

/* hdl/mac_rx_pkg.sv */
`default_nettype none

package mac_rx_pkg;

	localparam int DATA_W    = 64;		// beat data width
	localparam int CTRL_W    = 8;		// one enable bit per byte
	localparam int LEN_W     = 14;		// covers jumbo frames
	localparam int CNT_W     = 32;		// counter and register word
	localparam int N_STAT    = 12;		// words in the stat bank
	localparam int MIN_FRAME = 64;		// below this is undersize
	localparam int MAX_FRAME = 1518;	// above this is oversize

	// one assembled receive beat
	typedef struct packed {
		logic              vld;		// strobe, one cycle
		logic [DATA_W-1:0] data;	// first byte in 7:0
		logic [CTRL_W-1:0] byte_en;	// low bits set on a partial beat
		logic              sof;
		logic              eof;
	} rx_beat_t;

	// end of frame report
	typedef struct packed {
		logic             done;		// strobe with the eof beat
		logic [LEN_W-1:0] len;		// bytes in frame
		logic             err;		// gmii_rx_er seen
	} frame_info_t;

	typedef logic [3:0] reg_idx_t;			// host_addr_reg[5:2]
	typedef logic [CNT_W-1:0] reg_word_t;
	typedef logic [N_STAT-1:0][CNT_W-1:0] stat_bank_t;

	localparam reg_idx_t REG_PKT_CNT   = 4'd0;
	localparam reg_idx_t REG_BYTE_CNT  = 4'd1;
	localparam reg_idx_t REG_UNDERSIZE = 4'd2;
	localparam reg_idx_t REG_OVERSIZE  = 4'd3;
	localparam reg_idx_t REG_ERR_CNT   = 4'd4;
	localparam reg_idx_t REG_PHY_STAT  = 4'd5;	// bit 0 is linkup
	localparam reg_idx_t REG_BIN64     = 4'd6;
	localparam reg_idx_t REG_BIN127    = 4'd7;
	localparam reg_idx_t REG_BIN255    = 4'd8;
	localparam reg_idx_t REG_BIN511    = 4'd9;
	localparam reg_idx_t REG_BIN1023   = 4'd10;
	localparam reg_idx_t REG_BIN1518   = 4'd11;

endpackage

`default_nettype wire

/* hdl/mac_rx_top.sv */
`default_nettype none

module mac_rx_top
	#(
	parameter int LINK_QUAL = 16,
	parameter int RD_DELAY  = 5
	)
	(
	input  wire                   xauiA_clk,
	input  wire                   reset_,			// sync, active low
	input  wire  [7:0]            gmii_rxd,
	input  wire                   gmii_rx_dv,
	input  wire                   gmii_rx_er,
	input  wire                   fmac_rxd_en,		// whole frames only
	input  wire                   sfp_los,
	output mac_rx_pkg::rx_beat_t  rx_beat,
	output logic                  linkup,			// to LED
	input  wire                   reg_rd_start,
	input  wire  [15:0]           host_addr_reg,
	input  wire  [3:0]            SYS_ADDR,		// assigned to this MAC
	input  wire  [31:0]           fmac_ctrl,
	output mac_rx_pkg::reg_word_t FMAC_REGDOUT,
	output logic                  reg_rd_done_out
	);

	import mac_rx_pkg::*;

	frame_info_t frame_info;		// assembler to stats
	stat_bank_t  bank;
	logic        clear_stb;			// clear-on-read pulse
	reg_idx_t    clear_idx;

	gmii_rx_assembler #(
		.LINK_QUAL			(LINK_QUAL)
	) assembler_i (
		.xauiA_clk			(xauiA_clk),
		.reset_				(reset_),
		.gmii_rxd			(gmii_rxd),
		.gmii_rx_dv			(gmii_rx_dv),
		.gmii_rx_er			(gmii_rx_er),
		.fmac_rxd_en		(fmac_rxd_en),
		.sfp_los			(sfp_los),
		.rx_beat			(rx_beat),
		.frame_info			(frame_info),
		.linkup				(linkup)
	);

	rx_frame_stats stats_i (
		.xauiA_clk			(xauiA_clk),
		.reset_				(reset_),
		.frame_info			(frame_info),
		.linkup				(linkup),		// lands in REG_PHY_STAT
		.clear_stb			(clear_stb),
		.clear_idx			(clear_idx),
		.bank				(bank)
	);

	mac_register_if #(
		.RD_DELAY			(RD_DELAY)
	) reg_if_i (
		.xauiA_clk			(xauiA_clk),
		.reset_				(reset_),
		.reg_rd_start		(reg_rd_start),
		.host_addr_reg		(host_addr_reg),
		.SYS_ADDR			(SYS_ADDR),
		.fmac_ctrl			(fmac_ctrl),
		.bank				(bank),
		.FMAC_REGDOUT		(FMAC_REGDOUT),
		.reg_rd_done_out	(reg_rd_done_out),
		.clear_stb			(clear_stb),
		.clear_idx			(clear_idx)
	);

endmodule

`default_nettype wire

/* hdl/rx_frame_stats.sv */
`default_nettype none

module rx_frame_stats
	(
	input  wire                     xauiA_clk,
	input  wire                     reset_,
	input  wire mac_rx_pkg::frame_info_t frame_info,
	input  wire                     linkup,
	input  wire                     clear_stb,
	input  wire mac_rx_pkg::reg_idx_t clear_idx,
	output mac_rx_pkg::stat_bank_t  bank
	);

	import mac_rx_pkg::*;

	reg_idx_t   size_idx;		// the one size class counter
	stat_bank_t inc;			// per counter add value

	// size classification
	always_comb
	begin
		if (frame_info.len < MIN_FRAME)
			size_idx = REG_UNDERSIZE;
		else if (frame_info.len > MAX_FRAME)
			size_idx = REG_OVERSIZE;
		else if (frame_info.len == MIN_FRAME)
			size_idx = REG_BIN64;
		else if (frame_info.len <= 127)
			size_idx = REG_BIN127;
		else if (frame_info.len <= 255)
			size_idx = REG_BIN255;
		else if (frame_info.len <= 511)
			size_idx = REG_BIN511;
		else if (frame_info.len <= 1023)
			size_idx = REG_BIN1023;
		else
			size_idx = REG_BIN1518;			// 1024..MAX_FRAME
	end

	// increments for this cycle, all zero without done
	always_comb
	begin
		inc = '0;
		if (frame_info.done)
		begin
			inc[REG_PKT_CNT]  = CNT_W'(1);
			inc[REG_BYTE_CNT] = {{(CNT_W-LEN_W){1'b0}}, frame_info.len};
			inc[REG_ERR_CNT]  = {{(CNT_W-1){1'b0}}, frame_info.err};
			inc[size_idx]     = CNT_W'(1);
		end
	end

	// counter bank, clear-on-read
	always_ff @(posedge xauiA_clk)
	begin
		if (!reset_)
			bank <= '0;
		else
		begin
			for (int i = 0; i < N_STAT; i++)
			begin
				if (i == REG_PHY_STAT)
					bank[i] <= {{(CNT_W-1){1'b0}}, linkup};	// status, not a counter
				else if (clear_stb && (clear_idx == i))
					bank[i] <= inc[i];				// clear wins, keeps same-cycle add
				else
					bank[i] <= bank[i] + inc[i];
			end
		end
	end

endmodule

`default_nettype wire

/* mac_rx_top.f */
+incdir+include
hdl/mac_rx_pkg.sv
hdl/gmii_rx_assembler.sv
hdl/rx_frame_stats.sv
hdl/mac_register_if.sv
hdl/mac_rx_top.sv
tb/mac_rx_tb.sv

/* include/mac_rx_tb_checks.svh */
`ifndef MAC_RX_TB_CHECKS_SVH
`define MAC_RX_TB_CHECKS_SVH

// data compared on enabled lanes only
task automatic check_beat(input rx_beat_t got, input rx_beat_t exp);
	logic [DATA_W-1:0] mask;
	int                j;
	mask = '0;
	for (j = 0; j < CTRL_W; j++)
		if (exp.byte_en[j])
			mask[j*8 +: 8] = 8'hff;
	if (got.vld !== exp.vld || got.sof !== exp.sof || got.eof !== exp.eof ||
	    got.byte_en !== exp.byte_en || (got.data & mask) !== (exp.data & mask))
	begin
		$display("Fail rx_beat got 0x%h exp 0x%h", got, exp);
		fail_stop("rx_beat mismatch");
	end
endtask

task automatic check_reg(input string name, input reg_word_t got, input reg_word_t exp);
	if (got !== exp)
	begin
		$display("Fail %s got 0x%h exp 0x%h", name, got, exp);
		fail_stop("register value mismatch");
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("Fail %s got 0x%h exp 0x%h", name, got, exp);
		fail_stop("status bit mismatch");
	end
endtask

task automatic check_cycles(input string name, input int got, input int exp);
	if (got != exp)
	begin
		$display("Fail %s got 0x%h exp 0x%h", name, got, exp);
		fail_stop("latency mismatch");
	end
endtask

// linkup reaching a level within limit cycles
task automatic wait_link(input logic level, input int limit);
	int waited;
	waited = 0;
	while (linkup !== level && waited < limit)
	begin
		@(negedge xauiA_clk);
		waited++;
	end
	if (linkup !== level)
		fail_stop("linkup did not change level in time");
endtask

// monitor pops the queue as beats arrive
task automatic wait_beats_drained(input int limit);
	int waited;
	waited = 0;
	while (exp_beats.size() != 0 && waited < limit)
	begin
		@(negedge xauiA_clk);
		waited++;
	end
	if (exp_beats.size() != 0)
		fail_stop("expected beats of a frame did not arrive");
endtask

// start already dropped, first count is 1
task automatic wait_read_done(output int waited);
	waited = 1;
	while (reg_rd_done_out !== 1'b1 && waited < 4 * RD_DELAY)
	begin
		@(negedge xauiA_clk);
		waited++;
	end
	if (reg_rd_done_out !== 1'b1)
		fail_stop("reg_rd_done_out never followed reg_rd_start");
endtask

`endif

/* tb/mac_rx_tb.sv */
`default_nettype none

module mac_rx_tb;

	import mac_rx_pkg::*;

	localparam int LINK_QUAL = 16;
	localparam int RD_DELAY  = 5;
	localparam int N_FRAMES  = 10;

	typedef struct packed {
		logic [LEN_W-1:0] len;
		logic             err;		// gmii_rx_er mid frame
		logic             en;		// fmac_rxd_en at start
		logic [7:0]       first;	// bytes count up from here
	} frame_row_t;

	localparam frame_row_t PRE_LINK = '{14'd70, 1'b0, 1'b1, 8'he0};	// sent with link down

	frame_row_t frame_tab [N_FRAMES] = '{
		'{14'd64,   1'b0, 1'b1, 8'h00},	// exact 8 beats
		'{14'd67,   1'b0, 1'b1, 8'h10},	// partial last beat
		'{14'd72,   1'b0, 1'b1, 8'ha0},
		'{14'd80,   1'b0, 1'b0, 8'h33},	// rx disabled, dropped
		'{14'd40,   1'b1, 1'b1, 8'h40},	// undersize with error
		'{14'd64,   1'b0, 1'b1, 8'h50},
		'{14'd100,  1'b1, 1'b1, 8'h60},
		'{14'd300,  1'b0, 1'b1, 8'h70},
		'{14'd1518, 1'b1, 1'b1, 8'h80},
		'{14'd1600, 1'b0, 1'b1, 8'h90}	// oversize
	};

	logic        xauiA_clk;
	logic        reset_;
	logic [7:0]  gmii_rxd;
	logic        gmii_rx_dv;
	logic        gmii_rx_er;
	logic        fmac_rxd_en;
	logic        sfp_los;
	logic        reg_rd_start;
	logic [15:0] host_addr_reg;
	logic [3:0]  SYS_ADDR;
	logic [31:0] fmac_ctrl;
	rx_beat_t    rx_beat;
	logic        linkup;
	reg_word_t   FMAC_REGDOUT;
	logic        reg_rd_done_out;

	rx_beat_t    exp_beats [$];		// beats still to arrive
	reg_word_t   model [N_STAT];		// expected counters
	logic        link_model;
	logic        clr_model;			// auto clear expected on
	int          f;
	int          r;

	mac_rx_top #(
		.LINK_QUAL			(LINK_QUAL),
		.RD_DELAY			(RD_DELAY)
	) dut_i (
		.xauiA_clk			(xauiA_clk),
		.reset_				(reset_),
		.gmii_rxd			(gmii_rxd),
		.gmii_rx_dv			(gmii_rx_dv),
		.gmii_rx_er			(gmii_rx_er),
		.fmac_rxd_en		(fmac_rxd_en),
		.sfp_los			(sfp_los),
		.rx_beat			(rx_beat),
		.linkup				(linkup),
		.reg_rd_start		(reg_rd_start),
		.host_addr_reg		(host_addr_reg),
		.SYS_ADDR			(SYS_ADDR),
		.fmac_ctrl			(fmac_ctrl),
		.FMAC_REGDOUT		(FMAC_REGDOUT),
		.reg_rd_done_out	(reg_rd_done_out)
	);

	always #5 xauiA_clk = ~xauiA_clk;

	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	`include "mac_rx_tb_checks.svh"

	// every beat checked as it arrives
	always @(negedge xauiA_clk)
	begin
		if (reset_ === 1'b1 && rx_beat.vld === 1'b1)
		begin
			if (exp_beats.size() == 0)
				fail_stop("a beat arrived with none expected");
			else
				check_beat(rx_beat, exp_beats.pop_front());
		end
	end

	// 8 bytes per beat, first byte in lane 0
	task automatic queue_beats(input int len, input logic [7:0] first);
		rx_beat_t b;
		int       n;
		int       k;
		b     = '0;
		b.sof = 1'b1;
		n     = 0;
		for (k = 0; k < len; k++)
		begin
			b.data[n*8 +: 8] = first + 8'(k);
			b.byte_en[n]     = 1'b1;
			n++;
			if (n == 8 || k == len - 1)
			begin
				b.vld = 1'b1;
				b.eof = (k == len - 1);
				exp_beats.push_back(b);
				b = '0;			// sof only once
				n = 0;
			end
		end
	endtask

	task automatic count_frame(input int len, input logic err);
		model[REG_PKT_CNT]  += 1;
		model[REG_BYTE_CNT] += len;
		if (err)
			model[REG_ERR_CNT] += 1;
		if (len < MIN_FRAME)
			model[REG_UNDERSIZE] += 1;
		else if (len > MAX_FRAME)
			model[REG_OVERSIZE] += 1;
		else if (len == 64)
			model[REG_BIN64] += 1;
		else if (len <= 127)
			model[REG_BIN127] += 1;
		else if (len <= 255)
			model[REG_BIN255] += 1;
		else if (len <= 511)
			model[REG_BIN511] += 1;
		else if (len <= 1023)
			model[REG_BIN1023] += 1;
		else
			model[REG_BIN1518] += 1;
	endtask

	task automatic send_frame(input frame_row_t row);
		int i;
		if (row.en && link_model)	// accepted frames only
		begin
			queue_beats(row.len, row.first);
			count_frame(row.len, row.err);
		end
		for (i = 0; i < row.len; i++)
		begin
			@(negedge xauiA_clk);
			fmac_rxd_en = row.en;
			gmii_rx_dv  = 1'b1;
			gmii_rxd    = row.first + 8'(i);
			gmii_rx_er  = row.err && (i == row.len / 2);
		end
		@(negedge xauiA_clk);
		gmii_rx_dv = 1'b0;
		gmii_rx_er = 1'b0;
		gmii_rxd   = 8'h00;
		wait_beats_drained(16);
		repeat (12 + ($urandom % 8)) @(negedge xauiA_clk);	// idle gap
	endtask

	task automatic read_reg(input reg_idx_t idx, input logic sel);
		reg_word_t exp;
		int        waited;
		exp = '0;
		if (sel && idx == REG_PHY_STAT)
			exp = {{(CNT_W-1){1'b0}}, link_model};
		else if (sel && idx < N_STAT)
			exp = model[idx];
		@(negedge xauiA_clk);
		reg_rd_start  = 1'b1;
		host_addr_reg = {sel ? SYS_ADDR : ~SYS_ADDR, 6'd0, idx, 2'b00};
		@(negedge xauiA_clk);
		reg_rd_start = 1'b0;
		wait_read_done(waited);
		check_cycles("reg_rd_done_out latency", waited, RD_DELAY);
		check_reg($sformatf("FMAC_REGDOUT[%0d]", idx), FMAC_REGDOUT, exp);
		if (sel && clr_model && idx < N_STAT && idx != REG_PHY_STAT)
			model[idx] = '0;		// cleared on read
	endtask

	initial
	begin
		void'($urandom(48174));
		xauiA_clk     = 1'b0;
		reset_        = 1'b0;
		gmii_rxd      = 8'h00;
		gmii_rx_dv    = 1'b0;
		gmii_rx_er    = 1'b0;
		fmac_rxd_en   = 1'b1;
		sfp_los       = 1'b1;		// no light at start
		reg_rd_start  = 1'b0;
		host_addr_reg = '0;
		SYS_ADDR      = 4'h9;
		fmac_ctrl     = '0;
		link_model    = 1'b0;
		clr_model     = 1'b0;
		for (r = 0; r < N_STAT; r++)
			model[r] = '0;
		repeat (5) @(negedge xauiA_clk);
		reset_ = 1'b1;
		@(negedge xauiA_clk);
		check_bit("linkup", linkup, 1'b0);
		send_frame(PRE_LINK);		// no beats, no counts
		sfp_los = 1'b0;
		wait_link(1'b1, LINK_QUAL + 2);
		link_model = 1'b1;
		read_reg(REG_PKT_CNT, 1'b1);
		read_reg(REG_PHY_STAT, 1'b1);
		for (f = 0; f < N_FRAMES; f++)
			send_frame(frame_tab[f]);
		for (r = 0; r < 16; r++)
			read_reg(reg_idx_t'(r), 1'b1);	// 12..15 read zero
		read_reg(REG_PKT_CNT, 1'b1);		// no clear, value stays
		@(negedge xauiA_clk);
		fmac_ctrl[7] = 1'b1;				// rx_auto_clr_en
		clr_model    = 1'b1;
		repeat (2) @(negedge xauiA_clk);
		read_reg(REG_ERR_CNT, 1'b1);
		read_reg(REG_ERR_CNT, 1'b1);
		read_reg(REG_BIN64, 1'b0);		// other SYS_ADDR, no clear
		read_reg(REG_BIN64, 1'b1);
		read_reg(REG_BIN64, 1'b1);
		read_reg(REG_BYTE_CNT, 1'b1);
		read_reg(REG_BYTE_CNT, 1'b1);
		@(negedge xauiA_clk);
		sfp_los = 1'b1;
		wait_link(1'b0, 4);
		link_model = 1'b0;
		read_reg(REG_PHY_STAT, 1'b1);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
